//--- hdl/decoder.sv
`timescale 1ns/1ps

`include "mips_defs.svh"

module decoder
(
    input  mips_isa_pkg::word_t         i_instruction,
    output mips_isa_pkg::reg_addr_t     o_reg_a,
    output mips_isa_pkg::reg_addr_t     o_reg_b,
    output mips_isa_pkg::reg_addr_t     o_reg_w,
    output mips_isa_pkg::branch_kind_t  o_branch_kind,
    output mips_isa_pkg::imm_t          o_immediate,
    output mips_isa_pkg::index_t        o_index
);

    //////////////////////////////
    // Encodings.
    //////////////////////////////
    localparam mips_isa_pkg::opcode_t OP_SPECIAL = 6'd0;
    localparam mips_isa_pkg::opcode_t OP_J       = 6'd2;
    localparam mips_isa_pkg::opcode_t OP_JAL     = 6'd3;
    localparam mips_isa_pkg::opcode_t OP_BEQ     = 6'd4;
    localparam mips_isa_pkg::opcode_t OP_BNE     = 6'd5;

    localparam mips_isa_pkg::funct_t  FN_SLL     = 6'd0;
    localparam mips_isa_pkg::funct_t  FN_SRL     = 6'd2;
    localparam mips_isa_pkg::funct_t  FN_SRA     = 6'd3;
    localparam mips_isa_pkg::funct_t  FN_JR      = 6'd8;
    localparam mips_isa_pkg::funct_t  FN_JALR    = 6'd9;

    mips_isa_pkg::opcode_t  opcode;
    mips_isa_pkg::funct_t   funct;
    mips_isa_pkg::shamt_t   shamt;

    assign opcode = i_instruction[`MIPS_WORD_W - 1 -: `MIPS_OPCODE_W];
    assign funct  = i_instruction[`MIPS_FUNCT_W - 1 : 0];
    assign shamt  = i_instruction[`MIPS_FUNCT_W +: `MIPS_SHAMT_W];

    always_comb
    begin
        // Fixed field positions, every format.
        o_reg_a       = i_instruction[25:21];
        o_reg_b       = i_instruction[20:16];
        o_reg_w       = i_instruction[15:11];
        o_immediate   = i_instruction[`MIPS_IMM_W - 1 : 0];
        o_index       = i_instruction[`MIPS_INDEX_W - 1 : 0];
        o_branch_kind = mips_isa_pkg::BR_NONE;

        if (opcode == OP_SPECIAL)
        begin
            case (funct)
                FN_SLL, FN_SRL, FN_SRA:
                begin
                    // Shift amount rides in the immediate.
                    o_immediate = {{(`MIPS_IMM_W - `MIPS_SHAMT_W){1'b0}}, shamt};
                end
                FN_JR:
                begin
                    o_branch_kind = mips_isa_pkg::BR_JR;
                end
                FN_JALR:
                begin
                    o_branch_kind = mips_isa_pkg::BR_JALR;
                end
                default:
                begin
                    o_branch_kind = mips_isa_pkg::BR_NONE;
                end
            endcase
        end
        else
        begin
            case (opcode)
                OP_BEQ:
                begin
                    o_branch_kind = mips_isa_pkg::BR_BEQ;
                end
                OP_BNE:
                begin
                    o_branch_kind = mips_isa_pkg::BR_BNE;
                end
                OP_J:
                begin
                    o_branch_kind = mips_isa_pkg::BR_JUMP;
                end
                OP_JAL:
                begin
                    o_branch_kind = mips_isa_pkg::BR_JUMP;
                    o_reg_w       = `MIPS_LINK_REG;  // Return address goes to r31.
                end
                default:
                begin
                    o_branch_kind = mips_isa_pkg::BR_NONE;
                end
            endcase
        end
    end

endmodule

//--- hdl/if_id_latch.sv
`timescale 1ns/1ps

module if_id_latch
(
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  mips_isa_pkg::word_t  i_instruction,
    input  mips_pipe_pkg::pc_t   i_pc_plus4,
    input  logic                 i_valid,
    output mips_isa_pkg::word_t  o_instruction,
    output mips_pipe_pkg::pc_t   o_pc_plus4,
    output logic                 o_valid
);

    mips_isa_pkg::word_t  instruction_q;
    mips_pipe_pkg::pc_t   pc_plus4_q;
    logic                 valid_q;

    // Bubble after reset decodes as SLL r0 (a NOP).
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            instruction_q <= '0;
            pc_plus4_q    <= '0;
            valid_q       <= 1'b0;
        end
        else if (!i_stall)
        begin
            instruction_q <= i_instruction;
            pc_plus4_q    <= i_pc_plus4;
            valid_q       <= i_valid && !i_flush;  // Wrong-path word dies here.
        end
    end

    assign o_instruction = instruction_q;
    assign o_pc_plus4    = pc_plus4_q;
    assign o_valid       = valid_q;

endmodule

//--- hdl/instruction_decode.sv
`timescale 1ns/1ps

`include "mips_defs.svh"

module instruction_decode
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  mips_isa_pkg::word_t         i_instruction,
    input  mips_pipe_pkg::pc_t          i_pc_plus4,
    input  logic                        i_valid,
    input  logic                        i_wb_write,
    input  mips_isa_pkg::reg_addr_t     i_wb_reg,
    input  mips_isa_pkg::word_t         i_wb_data,
    output mips_isa_pkg::word_t         o_reg_a_data,
    output mips_isa_pkg::word_t         o_reg_b_data,
    output mips_isa_pkg::reg_addr_t     o_reg_w,
    output mips_isa_pkg::word_t         o_imm_ext,
    output mips_isa_pkg::branch_kind_t  o_branch_kind,
    output logic                        o_branch_taken,
    output mips_pipe_pkg::pc_t          o_branch_target,
    output logic                        o_valid
);

    localparam int NUM_REGS = 1 << `MIPS_REG_ADDR_W;

    mips_isa_pkg::word_t      regs [0 : NUM_REGS - 1];
    mips_isa_pkg::reg_addr_t  reg_a;
    mips_isa_pkg::reg_addr_t  reg_b;
    mips_isa_pkg::imm_t       immediate;
    mips_isa_pkg::index_t     index;
    mips_pipe_pkg::pc_t       rel_target;
    mips_pipe_pkg::pc_t       abs_target;
    logic                     cond_met;

    decoder decoder_i
    (
        .i_instruction (i_instruction),
        .o_reg_a       (reg_a),
        .o_reg_b       (reg_b),
        .o_reg_w       (o_reg_w),
        .o_branch_kind (o_branch_kind),
        .o_immediate   (immediate),
        .o_index       (index)
    );

    //////////////////////////////
    // Register file.
    //////////////////////////////
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (i_wb_write && i_wb_reg != '0)
            regs[i_wb_reg] <= i_wb_data;
    end

    // Same-cycle write is forwarded to the read.
    function automatic mips_isa_pkg::word_t read_reg(input mips_isa_pkg::reg_addr_t addr);
        mips_isa_pkg::word_t data;
        if (addr == '0)
            data = '0;
        else if (i_wb_write && i_wb_reg == addr)
            data = i_wb_data;
        else
            data = regs[addr];
        return data;
    endfunction

    always_comb
    begin
        o_reg_a_data = read_reg(reg_a);
        o_reg_b_data = read_reg(reg_b);
    end

    //////////////////////////////
    // Branch resolution.
    //////////////////////////////
    assign o_imm_ext  = {{(`MIPS_WORD_W - `MIPS_IMM_W){immediate[`MIPS_IMM_W - 1]}}, immediate};
    assign rel_target = i_pc_plus4 + {o_imm_ext[`MIPS_WORD_W - 3 : 0], 2'b00};
    assign abs_target = {i_pc_plus4[`MIPS_WORD_W - 1 -: 4], index, 2'b00};  // Same 256 MB region.

    always_comb
    begin
        cond_met        = 1'b0;
        o_branch_target = i_pc_plus4;
        case (o_branch_kind)
            mips_isa_pkg::BR_JR, mips_isa_pkg::BR_JALR:
            begin
                cond_met        = 1'b1;
                o_branch_target = o_reg_a_data;
            end
            mips_isa_pkg::BR_BEQ:
            begin
                cond_met        = (o_reg_a_data == o_reg_b_data);
                o_branch_target = rel_target;
            end
            mips_isa_pkg::BR_BNE:
            begin
                cond_met        = (o_reg_a_data != o_reg_b_data);
                o_branch_target = rel_target;
            end
            mips_isa_pkg::BR_JUMP:
            begin
                cond_met        = 1'b1;
                o_branch_target = abs_target;
            end
            default:
            begin
                cond_met = 1'b0;
            end
        endcase
    end

    assign o_branch_taken = i_valid && !i_stall && cond_met;  // Drives the redirect.
    assign o_valid        = i_valid;

endmodule

//--- hdl/instruction_fetch.sv
`timescale 1ns/1ps

`include "mips_defs.svh"

module instruction_fetch
(
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_start,
    input  logic                       i_stall,
    input  logic                       i_redirect,
    input  logic                       i_imem_write,
    input  mips_pipe_pkg::imem_addr_t  i_imem_addr,
    input  mips_isa_pkg::word_t        i_imem_data,
    input  mips_pipe_pkg::pc_t         i_target,
    output mips_isa_pkg::word_t        o_instruction,
    output mips_pipe_pkg::pc_t         o_pc_plus4,
    output logic                       o_fetch_valid,
    output logic                       o_halted
);

    localparam int IMEM_DEPTH = 1 << `MIPS_IMEM_ADDR_W;

    mips_isa_pkg::word_t          imem [0 : IMEM_DEPTH - 1];
    mips_pipe_pkg::pc_t           pc;
    mips_pipe_pkg::fetch_state_t  state;
    mips_pipe_pkg::imem_addr_t    fetch_addr;
    mips_isa_pkg::opcode_t        fetch_opcode;

    assign fetch_addr    = pc[`MIPS_IMEM_ADDR_W + 1 : 2];  // Drop byte offset.
    assign o_instruction = imem[fetch_addr];
    assign fetch_opcode  = o_instruction[`MIPS_WORD_W - 1 -: `MIPS_OPCODE_W];
    assign o_pc_plus4    = pc + 32'd4;
    assign o_fetch_valid = (state == mips_pipe_pkg::FETCH_RUN);
    assign o_halted      = (state == mips_pipe_pkg::FETCH_HALT);

    // Program load only while idle.
    always_ff @(posedge i_clock)
    begin
        if (i_imem_write && state == mips_pipe_pkg::FETCH_IDLE)
            imem[i_imem_addr] <= i_imem_data;
    end

    //////////////////////////////
    // PC and run state.
    //////////////////////////////
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            pc    <= '0;
            state <= mips_pipe_pkg::FETCH_IDLE;
        end
        else if (!i_stall)
        begin
            case (state)
                mips_pipe_pkg::FETCH_IDLE:
                begin
                    if (i_start)
                        state <= mips_pipe_pkg::FETCH_RUN;
                end
                mips_pipe_pkg::FETCH_RUN:
                begin
                    // A redirect squashes the word fetched this cycle, HALT included.
                    if (i_redirect)
                        pc <= i_target;
                    else if (fetch_opcode == `MIPS_HALT_OPCODE)
                        state <= mips_pipe_pkg::FETCH_HALT;  // PC parks on HALT.
                    else
                        pc <= o_pc_plus4;
                end
                default:
                begin
                    state <= mips_pipe_pkg::FETCH_HALT;
                end
            endcase
        end
    end

endmodule

//--- hdl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath and instruction widths.
`define MIPS_WORD_W       32
`define MIPS_REG_ADDR_W   5
`define MIPS_IMM_W        16
`define MIPS_INDEX_W      26
`define MIPS_SHAMT_W      5

//////////////////////////////
// Instruction fields.
//////////////////////////////
`define MIPS_OPCODE_W     6
`define MIPS_FUNCT_W      6
`define MIPS_BRANCH_W     3

// 64-word instruction memory.
`define MIPS_IMEM_ADDR_W  6

// Reserved opcode that stops fetch.
`define MIPS_HALT_OPCODE  6'b111111

// Written by JAL.
`define MIPS_LINK_REG     5'd31

`endif

//--- hdl/mips_front_end.sv
`timescale 1ns/1ps

module mips_front_end
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  logic                        i_stall,
    input  logic                        i_imem_write,
    input  mips_pipe_pkg::imem_addr_t   i_imem_addr,
    input  mips_isa_pkg::word_t         i_imem_data,
    input  logic                        i_wb_write,
    input  mips_isa_pkg::reg_addr_t     i_wb_reg,
    input  mips_isa_pkg::word_t         i_wb_data,
    output logic                        o_valid,
    output mips_isa_pkg::word_t         o_reg_a_data,
    output mips_isa_pkg::word_t         o_reg_b_data,
    output mips_isa_pkg::reg_addr_t     o_reg_w,
    output mips_isa_pkg::word_t         o_imm_ext,
    output mips_isa_pkg::branch_kind_t  o_branch_kind,
    output logic                        o_branch_taken,
    output mips_pipe_pkg::pc_t          o_branch_target,
    output logic                        o_halted
);

    mips_isa_pkg::word_t  if_instruction;
    mips_pipe_pkg::pc_t   if_pc_plus4;
    logic                 if_valid;
    mips_isa_pkg::word_t  id_instruction;
    mips_pipe_pkg::pc_t   id_pc_plus4;
    logic                 id_valid;

    //////////////////////////////
    // Fetch.
    //////////////////////////////
    instruction_fetch fetch_i
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_stall       (i_stall),
        .i_redirect    (o_branch_taken),   // Taken branch in decode.
        .i_imem_write  (i_imem_write),
        .i_imem_addr   (i_imem_addr),
        .i_imem_data   (i_imem_data),
        .i_target      (o_branch_target),
        .o_instruction (if_instruction),
        .o_pc_plus4    (if_pc_plus4),
        .o_fetch_valid (if_valid),
        .o_halted      (o_halted)
    );

    if_id_latch latch_i
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_flush       (o_branch_taken),   // No delay slot.
        .i_instruction (if_instruction),
        .i_pc_plus4    (if_pc_plus4),
        .i_valid       (if_valid),
        .o_instruction (id_instruction),
        .o_pc_plus4    (id_pc_plus4),
        .o_valid       (id_valid)
    );

    //////////////////////////////
    // Decode.
    //////////////////////////////
    instruction_decode decode_i
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_stall         (i_stall),
        .i_instruction   (id_instruction),
        .i_pc_plus4      (id_pc_plus4),
        .i_valid         (id_valid),
        .i_wb_write      (i_wb_write),
        .i_wb_reg        (i_wb_reg),
        .i_wb_data       (i_wb_data),
        .o_reg_a_data    (o_reg_a_data),
        .o_reg_b_data    (o_reg_b_data),
        .o_reg_w         (o_reg_w),
        .o_imm_ext       (o_imm_ext),
        .o_branch_kind   (o_branch_kind),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_valid         (o_valid)
    );

endmodule

//--- hdl/mips_isa_pkg.sv
`include "mips_defs.svh"

package mips_isa_pkg;

    //////////////////////////////
    // Field types.
    //////////////////////////////
    typedef logic [`MIPS_WORD_W - 1 : 0]     word_t;       // Data and instruction word.
    typedef logic [`MIPS_REG_ADDR_W - 1 : 0] reg_addr_t;   // Register number.
    typedef logic [`MIPS_IMM_W - 1 : 0]      imm_t;        // I-type immediate.
    typedef logic [`MIPS_INDEX_W - 1 : 0]    index_t;      // J-type target index.
    typedef logic [`MIPS_OPCODE_W - 1 : 0]   opcode_t;     // Top six bits.
    typedef logic [`MIPS_FUNCT_W - 1 : 0]    funct_t;      // R-type function code.
    typedef logic [`MIPS_SHAMT_W - 1 : 0]    shamt_t;      // Shift amount.
    typedef logic [`MIPS_BRANCH_W - 1 : 0]   branch_kind_t;

    //////////////////////////////
    // Branch kinds.
    //////////////////////////////
    localparam branch_kind_t BR_NONE = branch_kind_t'(0);
    localparam branch_kind_t BR_JR   = branch_kind_t'(1);
    localparam branch_kind_t BR_JALR = branch_kind_t'(2);
    localparam branch_kind_t BR_BEQ  = branch_kind_t'(3);
    localparam branch_kind_t BR_BNE  = branch_kind_t'(4);

    // J and JAL share one kind, JAL differs only in its write register.
    localparam branch_kind_t BR_JUMP = branch_kind_t'(5);

endpackage

//--- hdl/mips_pipe_pkg.sv
`include "mips_defs.svh"

package mips_pipe_pkg;

    // Byte address, always word aligned.
    typedef logic [`MIPS_WORD_W - 1 : 0] pc_t;

    // Word index into the instruction memory.
    typedef logic [`MIPS_IMEM_ADDR_W - 1 : 0] imem_addr_t;

    //////////////////////////////
    // Fetch run control.
    //////////////////////////////
    typedef enum logic [1:0]
    {
        FETCH_IDLE,     // Waiting for start.
        FETCH_RUN,      // Fetching each cycle.
        FETCH_HALT      // Left only by reset.
    } fetch_state_t;

endpackage

//--- mips_front_end.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/decoder.sv
hdl/instruction_fetch.sv
hdl/if_id_latch.sv
hdl/instruction_decode.sv
hdl/mips_front_end.sv
verif/tb_clock_gen.sv
verif/mips_front_end_checker.sv
verif/mips_front_end_tb.sv

//--- verif/mips_front_end_checker.sv
`timescale 1ns/1ps

module mips_front_end_checker
(
    input logic                        i_clock,
    input logic                        i_reset,
    input logic                        i_stall,
    input logic                        i_wb_write,
    input logic                        i_valid,
    input mips_isa_pkg::word_t         i_reg_a_data,
    input mips_isa_pkg::word_t         i_reg_b_data,
    input mips_isa_pkg::reg_addr_t     i_reg_w,
    input mips_isa_pkg::word_t         i_imm_ext,
    input mips_isa_pkg::branch_kind_t  i_branch_kind,
    input logic                        i_branch_taken,
    input mips_pipe_pkg::pc_t          i_branch_target,
    input logic                        i_halted
);

    int error_count = 0;

    //////////////////////////////
    // Reset and halt.
    //////////////////////////////
    reset_quiet: assert property (@(posedge i_clock)
        i_reset |=> !i_valid && !i_branch_taken && !i_halted)
        else
        begin
            $error("outputs active right after reset");
            error_count++;
        end

    halt_sticky: assert property (@(posedge i_clock) disable iff (i_reset)
        i_halted |=> i_halted)
        else
        begin
            $error("halt dropped without reset");
            error_count++;
        end

    halt_drained: assert property (@(posedge i_clock) disable iff (i_reset)
        i_halted && $past(i_halted) |-> !i_valid)
        else
        begin
            $error("valid decode after halt");
            error_count++;
        end

    //////////////////////////////
    // Redirect.
    //////////////////////////////

    // One bubble before the target word.
    redirect_bubble: assert property (@(posedge i_clock) disable iff (i_reset || i_stall)
        i_branch_taken |=> !i_valid ##1 i_valid)
        else
        begin
            $error("taken branch not followed by exactly one bubble");
            error_count++;
        end

    // Outputs frozen while stalled and no register write lands.
    stall_hold: assert property (@(posedge i_clock) disable iff (i_reset)
        i_stall && $past(i_stall) && !i_wb_write |->
            $stable(i_valid) && $stable(i_reg_a_data) && $stable(i_reg_b_data)
            && $stable(i_reg_w) && $stable(i_imm_ext) && $stable(i_branch_kind)
            && $stable(i_branch_taken) && $stable(i_branch_target))
        else
        begin
            $error("decode outputs moved during stall");
            error_count++;
        end

endmodule

bind mips_front_end mips_front_end_checker checker_i
(
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_stall         (i_stall),
    .i_wb_write      (i_wb_write),
    .i_valid         (o_valid),
    .i_reg_a_data    (o_reg_a_data),
    .i_reg_b_data    (o_reg_b_data),
    .i_reg_w         (o_reg_w),
    .i_imm_ext       (o_imm_ext),
    .i_branch_kind   (o_branch_kind),
    .i_branch_taken  (o_branch_taken),
    .i_branch_target (o_branch_target),
    .i_halted        (o_halted)
);

//--- verif/mips_front_end_tb.sv
`timescale 1ns/1ps

module mips_front_end_tb;

    localparam int PROG_LEN        = 26;
    localparam int NUM_EXP         = 13;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 10 + 200;  // Program plus load and setup.

    logic clock;
    logic reset;
    logic start;
    logic stall;
    logic imem_write;
    mips_pipe_pkg::imem_addr_t imem_addr;
    mips_isa_pkg::word_t imem_data;
    logic wb_write;
    mips_isa_pkg::reg_addr_t wb_reg;
    mips_isa_pkg::word_t wb_data;
    logic o_valid;
    mips_isa_pkg::word_t o_reg_a_data;
    mips_isa_pkg::word_t o_reg_b_data;
    mips_isa_pkg::reg_addr_t o_reg_w;
    mips_isa_pkg::word_t o_imm_ext;
    mips_isa_pkg::branch_kind_t o_branch_kind;
    logic o_branch_taken;
    mips_pipe_pkg::pc_t o_branch_target;
    logic o_halted;

    logic [31:0] lfsr_state;
    mips_isa_pkg::word_t val_a;
    mips_isa_pkg::word_t val_b;
    mips_isa_pkg::word_t val_r6;
    mips_isa_pkg::word_t val_bypass;
    mips_isa_pkg::word_t val_r0;
    mips_isa_pkg::word_t exp_fields [0 : NUM_EXP - 1][0 : 6];  // w, a, b, imm, kind, taken, target.
    int exp_n;
    int seen;

    tb_clock_gen clock_gen_i (.o_clock(clock), .o_reset(reset));

    mips_front_end dut_i
    (
        .i_clock (clock), .i_reset (reset), .i_start (start), .i_stall (stall),
        .i_imem_write (imem_write), .i_imem_addr (imem_addr), .i_imem_data (imem_data),
        .i_wb_write (wb_write), .i_wb_reg (wb_reg), .i_wb_data (wb_data),
        .o_valid (o_valid), .o_reg_a_data (o_reg_a_data), .o_reg_b_data (o_reg_b_data),
        .o_reg_w (o_reg_w), .o_imm_ext (o_imm_ext), .o_branch_kind (o_branch_kind),
        .o_branch_taken (o_branch_taken), .o_branch_target (o_branch_target),
        .o_halted (o_halted)
    );

    // Taps 32, 22, 2, 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic mips_isa_pkg::word_t rand_word();
        mips_isa_pkg::word_t v;
        for (int i = 0; i < 32; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic mips_isa_pkg::word_t r_word(input int rs, rt, rd, sh, input int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic mips_isa_pkg::word_t i_word(input int op, rs, rt, input logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    function automatic mips_isa_pkg::word_t j_word(input int op, input int index);
        return {6'(op), 26'(index)};
    endfunction

    task automatic write_imem(input int addr, input mips_isa_pkg::word_t data);
        @(posedge clock);
        #2;
        imem_write = 1'b1;
        imem_addr  = mips_pipe_pkg::imem_addr_t'(addr);
        imem_data  = data;
    endtask

    task automatic write_reg(input int r, input mips_isa_pkg::word_t data);
        @(posedge clock);
        #2;
        wb_write = 1'b1;
        wb_reg   = mips_isa_pkg::reg_addr_t'(r);
        wb_data  = data;
    endtask

    task automatic expect_decode(input mips_isa_pkg::word_t w, a, b, imm, kind, taken, target);
        exp_fields[exp_n] = '{w, a, b, imm, kind, taken, target};
        exp_n++;
    endtask

    task automatic check_value(input string name, input mips_isa_pkg::word_t got, expv);
        assert (got === expv)
        else
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expv);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Decode monitor.
    //////////////////////////////
    always @(negedge clock)
    begin
        if (!reset && o_valid && !stall)
        begin
            assert (seen < NUM_EXP)
            else
            begin
                $display("Decode produced more instructions than the program path holds.");
                $display("RESULT: FAIL");
                $fatal(1);
            end
            check_value("o_reg_w", o_reg_w, exp_fields[seen][0]);
            check_value("o_reg_a_data", o_reg_a_data, exp_fields[seen][1]);
            check_value("o_reg_b_data", o_reg_b_data, exp_fields[seen][2]);
            check_value("o_imm_ext", o_imm_ext, exp_fields[seen][3]);
            check_value("o_branch_kind", o_branch_kind, exp_fields[seen][4]);
            check_value("o_branch_taken", o_branch_taken, exp_fields[seen][5]);
            if (exp_fields[seen][4] != mips_isa_pkg::BR_NONE)
                check_value("o_branch_target", o_branch_target, exp_fields[seen][6]);
            seen++;
        end
    end

    // Bound checker.
    always @(negedge clock)
    begin
        if (dut_i.checker_i.error_count != 0)
        begin
            $display("A checker assertion failed.");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 40ns);
        $display("Timeout, the program never reached its halt.");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    initial
    begin
        start      = 1'b0;
        stall      = 1'b0;
        imem_write = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        wb_write   = 1'b0;
        wb_reg     = '0;
        wb_data    = '0;
        exp_n      = 0;
        seen       = 0;
        lfsr_state = 32'hc838b9f7;
        wait (!reset);
        @(negedge clock);
        check_value("o_valid", o_valid, 0);
        check_value("o_branch_taken", o_branch_taken, 0);
        check_value("o_halted", o_halted, 0);

        val_a      = rand_word();
        val_b      = rand_word();
        val_r6     = rand_word();
        val_bypass = rand_word();
        val_r0     = rand_word();
        if (val_b == val_a)
            val_b = ~val_a;

        // Filler words carry rd 30 and their own address.
        for (int i = 0; i < 64; i++)
            write_imem(i, {6'd0, 4'd0, 6'(i), 5'd30, 11'd0});
        write_imem(0, r_word(0, 1, 10, 3, 0));            // SLL
        write_imem(1, r_word(5, 2, 11, 7, 2));            // SRL
        write_imem(2, r_word(6, 3, 12, 31, 3));           // SRA, stalled here.
        write_imem(3, i_word(4, 1, 3, 16'hfffb));         // BEQ not taken.
        write_imem(4, i_word(5, 1, 2, 16'd7));            // BNE not taken.
        write_imem(5, i_word(4, 1, 2, 16'd2));            // BEQ to 8.
        write_imem(8, i_word(5, 1, 3, 16'd2));            // BNE to 11.
        write_imem(11, j_word(2, 14));                    // J to 14.
        write_imem(14, r_word(4, 0, 0, 0, 8));            // JR r4 to 18.
        write_imem(18, j_word(3, 21));                    // JAL to 21.
        write_imem(21, r_word(7, 0, 31, 0, 9));           // JALR r7 to 24.
        write_imem(24, r_word(0, 0, 13, 0, 0));           // Landing marker.
        write_imem(25, 32'hfc00_0000);                    // HALT
        @(posedge clock);
        #2;
        imem_write = 1'b0;

        write_reg(0, val_r0);
        write_reg(1, val_a);
        write_reg(2, val_a);
        write_reg(3, val_b);
        write_reg(4, 32'd72);
        write_reg(6, val_r6);
        write_reg(7, 32'd96);
        @(posedge clock);
        #2;
        wb_write = 1'b0;

        expect_decode(10, 0, val_a, 3, 0, 0, 0);
        expect_decode(11, 0, val_a, 7, 0, 0, 0);
        expect_decode(12, val_bypass, val_b, 31, 0, 0, 0);
        expect_decode(31, val_a, val_b, 32'hfffffffb, 3, 0, 32'hfffffffc);
        expect_decode(0, val_a, val_a, 7, 4, 0, 48);
        expect_decode(0, val_a, val_a, 2, 3, 1, 32);
        expect_decode(0, val_a, val_b, 2, 4, 1, 44);
        expect_decode(0, 0, 0, 14, 5, 1, 56);
        expect_decode(0, 72, 0, 8, 1, 1, 72);
        expect_decode(31, 0, 0, 21, 5, 1, 84);
        expect_decode(31, 96, 0, 32'hfffff809, 2, 1, 96);
        expect_decode(13, 0, 0, 0, 0, 0, 0);
        expect_decode(0, 0, 0, 0, 0, 0, 0);

        @(posedge clock);
        #2;
        start = 1'b1;
        @(posedge clock);
        #2;
        start = 1'b0;

        // Hold the SRA word and overwrite r6 under stall.
        while (!(o_valid && o_reg_w == 5'd12))
        begin
            @(posedge clock);
            #2;
        end
        stall = 1'b1;
        @(posedge clock);
        #2;
        wb_write = 1'b1;
        wb_reg   = 5'd6;
        wb_data  = val_bypass;
        @(negedge clock);
        check_value("o_reg_a_data", o_reg_a_data, val_bypass);
        @(posedge clock);
        #2;
        wb_write = 1'b0;
        @(posedge clock);
        #2;
        stall = 1'b0;

        wait (o_halted);
        repeat (4) @(posedge clock);
        @(negedge clock);
        if (seen == NUM_EXP && dut_i.checker_i.error_count == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Decode saw %0d of %0d expected instructions, %0d checker errors.",
                     seen, NUM_EXP, dut_i.checker_i.error_count);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);

    localparam time HALF_PERIOD = 20ns;

    initial
    begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

    // Two full cycles of reset.
    initial
    begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clock);
        #2;
        o_reset = 1'b0;
    end

endmodule
